// File: hw/dlx_pkg.sv
package dlx_pkg;

    // basic data types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // primary opcodes, R-type has its own
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQZ  = 6'h04,
        OP_BNEZ  = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    // R-type function codes
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_XOR = 6'h26,
        FN_SLT = 6'h2a
    } func_t;

    // add is zero so a bubble decodes as a harmless add
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    // field positions, msb first: opcode, rs1, rs2, then rd or immediate
    localparam int OPC_LSB  = 26;
    localparam int OPC_W    = 6;
    localparam int RS1_LSB  = 21;
    localparam int RS2_LSB  = 16;
    localparam int RD_LSB   = 11;
    localparam int REG_W    = 5;
    localparam int FUNC_LSB = 0;
    localparam int FUNC_W   = 6;
    localparam int IMM_W    = 16;
    localparam int OFF_W    = 26;

    typedef struct packed {
        word_t next_pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        word_t    next_pc;
        word_t    op_a;
        word_t    op_b;
        word_t    store_data;
        word_t    imm;
        word_t    offset;
        reg_idx_t dest;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     reg_write;
        logic     mem_to_reg;
        logic     mem_write;
        logic     use_imm;
        logic     branch;
        logic     branch_zero;
        logic     jump;
        alu_op_t  alu_op;
    } id_ex_t;

    typedef struct packed {
        word_t    alu_result;
        word_t    store_data;
        word_t    leap_addr;
        logic     leap;
        reg_idx_t dest;
        reg_idx_t rs2;
        logic     reg_write;
        logic     mem_to_reg;
        logic     mem_write;
    } ex_mem_t;

    typedef struct packed {
        word_t    alu_result;
        word_t    load_data;
        reg_idx_t dest;
        logic     reg_write;
        logic     mem_to_reg;
    } mem_wb_t;

endpackage

// File: hw/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     hold,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // all-zero payload is the bubble, every control flag inactive
    // flush beats hold
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter dlx_pkg::word_t RESET_PC = '0
) (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           stall,
    input  logic           leap,
    input  dlx_pkg::word_t leap_addr,
    output dlx_pkg::word_t fetch_addr,
    output dlx_pkg::word_t next_pc
);
    import dlx_pkg::*;

    word_t pc;

    // leap target goes straight to imem, no wait for the pc
    assign fetch_addr = leap ? leap_addr : pc;
    assign next_pc    = fetch_addr + 32'd4;

    // stalled pc refetches the same word next cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            pc <= next_pc;
        end
    end

endmodule

// File: hw/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic              clk,
    input  logic              arst_n,
    input  dlx_pkg::reg_idx_t rs1,
    input  dlx_pkg::reg_idx_t rs2,
    input  dlx_pkg::reg_idx_t rd,
    input  logic              we,
    input  dlx_pkg::word_t    wdata,
    output dlx_pkg::word_t    rs1_val,
    output dlx_pkg::word_t    rs2_val
);
    import dlx_pkg::*;

    word_t regs [32];
    logic  wr_live;

    // r0 never written
    assign wr_live = we && (rd != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[rd] <= wdata;
        end
    end

    // write-through, decode sees the write-back value in the same cycle
    assign rs1_val = (wr_live && rd == rs1) ? wdata : regs[rs1];
    assign rs2_val = (wr_live && rd == rs2) ? wdata : regs[rs2];

endmodule

// File: hw/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
    input  dlx_pkg::word_t    instr,
    input  dlx_pkg::word_t    next_pc,
    input  dlx_pkg::word_t    rs1_val,
    input  dlx_pkg::word_t    rs2_val,
    output dlx_pkg::reg_idx_t rs1,
    output dlx_pkg::reg_idx_t rs2,
    output dlx_pkg::id_ex_t   entry
);
    import dlx_pkg::*;

    opcode_t          opcode;
    func_t            func;
    reg_idx_t         rd;
    logic [IMM_W-1:0] imm16;
    logic [OFF_W-1:0] off26;
    word_t            sext16;
    word_t            zext16;
    word_t            sext26;
    logic             legal;
    logic             reads_rs1;
    logic             reads_rs2;
    id_ex_t           ctl;

    // raw fields
    assign opcode = opcode_t'(instr[OPC_LSB +: OPC_W]);
    assign func   = func_t'(instr[FUNC_LSB +: FUNC_W]);
    assign rs1    = instr[RS1_LSB +: REG_W];
    assign rs2    = instr[RS2_LSB +: REG_W];
    assign rd     = instr[RD_LSB +: REG_W];
    assign imm16  = instr[IMM_W-1:0];
    assign off26  = instr[OFF_W-1:0];

    assign sext16 = {{(32-IMM_W){imm16[IMM_W-1]}}, imm16};
    assign zext16 = {{(32-IMM_W){1'b0}}, imm16};
    assign sext26 = {{(32-OFF_W){off26[OFF_W-1]}}, off26};

    always_comb begin
        ctl       = '0;
        legal     = 1'b1;
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                reads_rs2     = 1'b1;
                ctl.reg_write = 1'b1;
                ctl.dest      = rd;
                case (func)
                    FN_ADD:  ctl.alu_op = ALU_ADD;
                    FN_SUB:  ctl.alu_op = ALU_SUB;
                    FN_AND:  ctl.alu_op = ALU_AND;
                    FN_OR:   ctl.alu_op = ALU_OR;
                    FN_XOR:  ctl.alu_op = ALU_XOR;
                    FN_SLT:  ctl.alu_op = ALU_SLT;
                    default: legal = 1'b0;
                endcase
            end
            // immediates and loads write the rs2 field
            OP_ADDI, OP_ANDI, OP_ORI, OP_LW: begin
                ctl.use_imm    = 1'b1;
                ctl.reg_write  = 1'b1;
                ctl.dest       = rs2;
                ctl.mem_to_reg = (opcode == OP_LW);
                ctl.imm        = (opcode == OP_ANDI || opcode == OP_ORI) ? zext16 : sext16;
                ctl.alu_op     = (opcode == OP_ANDI) ? ALU_AND :
                                 (opcode == OP_ORI)  ? ALU_OR  : ALU_ADD;
            end
            // address from rs1 + imm, data from rs2
            OP_SW: begin
                reads_rs2     = 1'b1;
                ctl.use_imm   = 1'b1;
                ctl.mem_write = 1'b1;
                ctl.imm       = sext16;
            end
            OP_BEQZ, OP_BNEZ: begin
                ctl.branch      = 1'b1;
                ctl.branch_zero = (opcode == OP_BEQZ);
                ctl.offset      = sext16;
            end
            OP_J: begin
                reads_rs1 = 1'b0;
                ctl.jump   = 1'b1;
                ctl.offset = sext26;
            end
            default: legal = 1'b0;
        endcase

        ctl.next_pc = next_pc;
        ctl.op_a    = rs1_val;
        // rs2 rides in op_b for alu ops, in store_data for stores
        ctl.op_b       = ctl.use_imm ? '0 : rs2_val;
        ctl.store_data = ctl.mem_write ? rs2_val : '0;
        // unread operands become r0 so nothing forwards into them
        ctl.rs1 = reads_rs1 ? rs1 : '0;
        ctl.rs2 = reads_rs2 ? rs2 : '0;
    end

    // unknown encodings go down the pipe as bubbles
    assign entry = legal ? ctl : '0;

endmodule

// File: hw/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  dlx_pkg::id_ex_t  entry,
    input  dlx_pkg::word_t   op_a,
    input  dlx_pkg::word_t   op_b,
    output dlx_pkg::ex_mem_t result
);
    import dlx_pkg::*;

    word_t alu_b;
    word_t alu_out;
    logic  a_is_zero;
    logic  taken;

    assign alu_b = entry.use_imm ? entry.imm : op_b;

    always_comb begin
        case (entry.alu_op)
            ALU_ADD: alu_out = op_a + alu_b;
            ALU_SUB: alu_out = op_a - alu_b;
            ALU_AND: alu_out = op_a & alu_b;
            ALU_OR:  alu_out = op_a | alu_b;
            ALU_XOR: alu_out = op_a ^ alu_b;
            // signed compare, 1 or 0
            ALU_SLT: alu_out = {31'b0, $signed(op_a) < $signed(alu_b)};
            default: alu_out = '0;
        endcase
    end

    // beqz / bnez test operand a only
    assign a_is_zero = (op_a == '0);
    assign taken     = entry.jump ||
                       (entry.branch && (entry.branch_zero ? a_is_zero : !a_is_zero));

    // leap is only acted on once it sits in ex/mem
    assign result.alu_result = alu_out;
    assign result.store_data = op_b;
    assign result.leap_addr  = entry.next_pc + entry.offset;
    assign result.leap       = taken;
    assign result.dest       = entry.dest;
    assign result.rs2        = entry.rs2;
    assign result.reg_write  = entry.reg_write;
    assign result.mem_to_reg = entry.mem_to_reg;
    assign result.mem_write  = entry.mem_write;

endmodule

// File: hw/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  dlx_pkg::id_ex_t  id_entry,
    input  dlx_pkg::id_ex_t  ex_entry,
    input  dlx_pkg::ex_mem_t mem_entry,
    input  dlx_pkg::mem_wb_t wb_entry,
    input  dlx_pkg::word_t   wb_value,
    input  dlx_pkg::word_t   fetched_instr,
    output dlx_pkg::word_t   op_a,
    output dlx_pkg::word_t   op_b,
    output dlx_pkg::word_t   store_data,
    output logic             stall
);
    import dlx_pkg::*;

    logic     mem_can_fwd;
    logic     wb_can_fwd;
    word_t    rs2_base;
    reg_idx_t if_rs1;
    reg_idx_t if_rs2;

    ////////////////////////////////////////////////////////////////////////////
    // forwarding into execute
    ////////////////////////////////////////////////////////////////////////////

    // load data is not ready in mem, the stall covers that case
    assign mem_can_fwd = mem_entry.reg_write && !mem_entry.mem_to_reg &&
                         (mem_entry.dest != '0);
    assign wb_can_fwd  = wb_entry.reg_write && (wb_entry.dest != '0);

    // rs2 value carried by the entry, store or alu op
    assign rs2_base = ex_entry.mem_write ? ex_entry.store_data : ex_entry.op_b;

    // mem stage is younger, checked first
    assign op_a = (mem_can_fwd && mem_entry.dest == ex_entry.rs1) ? mem_entry.alu_result :
                  (wb_can_fwd && wb_entry.dest == ex_entry.rs1)   ? wb_value :
                                                                    ex_entry.op_a;
    assign op_b = (mem_can_fwd && mem_entry.dest == ex_entry.rs2) ? mem_entry.alu_result :
                  (wb_can_fwd && wb_entry.dest == ex_entry.rs2)   ? wb_value :
                                                                    rs2_base;

    ////////////////////////////////////////////////////////////////////////////
    // store data in the memory stage
    ////////////////////////////////////////////////////////////////////////////

    assign store_data = (mem_entry.mem_write && wb_can_fwd &&
                         wb_entry.dest == mem_entry.rs2) ? wb_value : mem_entry.store_data;

    ////////////////////////////////////////////////////////////////////////////
    // load-use
    ////////////////////////////////////////////////////////////////////////////

    // load sitting in decode, consumer coming out of imem
    assign if_rs1 = fetched_instr[RS1_LSB +: REG_W];
    assign if_rs2 = fetched_instr[RS2_LSB +: REG_W];

    assign stall = id_entry.mem_to_reg && (id_entry.dest != '0) &&
                   (id_entry.dest == if_rs1 || id_entry.dest == if_rs2);

endmodule

// File: hw/dlx_core.sv
`timescale 1ns/1ps

module dlx_core #(
    parameter dlx_pkg::word_t RESET_PC = '0
) (
    input  logic           clk,
    input  logic           arst_n,
    output dlx_pkg::word_t imem_addr,
    input  dlx_pkg::word_t imem_instr,
    output dlx_pkg::word_t dmem_addr,
    output dlx_pkg::word_t dmem_wdata,
    output logic           dmem_we,
    input  dlx_pkg::word_t dmem_rdata
);
    import dlx_pkg::*;

    if_id_t   if_id_d, if_id_q;
    id_ex_t   id_ex_d, id_ex_q;
    ex_mem_t  ex_mem_d, ex_mem_q;
    mem_wb_t  mem_wb_d, mem_wb_q;
    word_t    next_pc;
    reg_idx_t rs1, rs2;
    word_t    rs1_val, rs2_val;
    word_t    op_a, op_b, store_data;
    word_t    wb_value;
    logic     load_stall, stall, leap;

    ////////////////////////////////////////////////////////////////////////////
    // fetch
    ////////////////////////////////////////////////////////////////////////////

    // leap decided in ex, acted on from ex/mem
    assign leap = ex_mem_q.leap;
    // a leap flushes the load that caused the stall
    assign stall = load_stall && !leap;

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .arst_n(arst_n), .stall(stall), .leap(leap),
        .leap_addr(ex_mem_q.leap_addr), .fetch_addr(imem_addr), .next_pc(next_pc)
    );

    assign if_id_d.next_pc = next_pc;
    assign if_id_d.instr   = imem_instr;

    // leap target is fetched in the leap cycle, so if/id keeps it
    // stall drops the fetched word, pc refetches it
    stage_reg #(.payload_t(if_id_t)) u_if_id (
        .clk(clk), .arst_n(arst_n), .hold(1'b0), .flush(stall), .d(if_id_d), .q(if_id_q)
    );

    ////////////////////////////////////////////////////////////////////////////
    // decode and execute
    ////////////////////////////////////////////////////////////////////////////

    decode_unit u_decode (
        .instr(if_id_q.instr), .next_pc(if_id_q.next_pc), .rs1_val(rs1_val),
        .rs2_val(rs2_val), .rs1(rs1), .rs2(rs2), .entry(id_ex_d)
    );

    // write port straight from write-back
    register_file u_regs (
        .clk(clk), .arst_n(arst_n), .rs1(rs1), .rs2(rs2), .rd(mem_wb_q.dest),
        .we(mem_wb_q.reg_write), .wdata(wb_value), .rs1_val(rs1_val), .rs2_val(rs2_val)
    );

    // two younger instructions squashed on a leap
    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk(clk), .arst_n(arst_n), .hold(1'b0), .flush(leap), .d(id_ex_d), .q(id_ex_q)
    );

    execute_unit u_execute (.entry(id_ex_q), .op_a(op_a), .op_b(op_b), .result(ex_mem_d));

    stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk(clk), .arst_n(arst_n), .hold(1'b0), .flush(leap), .d(ex_mem_d), .q(ex_mem_q)
    );

    hazard_unit u_hazard (
        .id_entry(id_ex_d), .ex_entry(id_ex_q), .mem_entry(ex_mem_q), .wb_entry(mem_wb_q),
        .wb_value(wb_value), .fetched_instr(imem_instr), .op_a(op_a), .op_b(op_b),
        .store_data(store_data), .stall(load_stall)
    );

    ////////////////////////////////////////////////////////////////////////////
    // memory and write-back
    ////////////////////////////////////////////////////////////////////////////

    // dmem answers within the cycle, store lands on the edge
    assign dmem_addr  = ex_mem_q.alu_result;
    assign dmem_wdata = store_data;
    assign dmem_we    = ex_mem_q.mem_write;

    assign mem_wb_d.alu_result = ex_mem_q.alu_result;
    assign mem_wb_d.load_data  = dmem_rdata;
    assign mem_wb_d.dest       = ex_mem_q.dest;
    assign mem_wb_d.reg_write  = ex_mem_q.reg_write;
    assign mem_wb_d.mem_to_reg = ex_mem_q.mem_to_reg;

    // leaping instruction itself retires normally
    stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk(clk), .arst_n(arst_n), .hold(1'b0), .flush(1'b0), .d(mem_wb_d), .q(mem_wb_q)
    );

    // load data or alu result
    assign wb_value = mem_wb_q.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_result;

endmodule

// File: tb/dlx_programs.svh
`ifndef DLX_PROGRAMS_SVH
`define DLX_PROGRAMS_SVH

// shadow stores of a taken leap aim here
localparam word_t POISON_ADDR = 32'h0000_07f0;

function automatic word_t encode_r(func_t fn, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
    return {OP_RTYPE, rs1, rs2, rd, 5'b0, fn};
endfunction

// rs2 is the destination, or the store data register for sw
function automatic word_t encode_i(opcode_t op, reg_idx_t rs1, reg_idx_t rs2, logic [15:0] imm);
    return {op, rs1, rs2, imm};
endfunction

function automatic word_t encode_j(logic [25:0] off);
    return {OP_J, off};
endfunction

function automatic word_t sign_extend(logic [15:0] v);
    return {{16{v[15]}}, v};
endfunction

////////////////////////////////////////////////////////////////////////////
// program builders, each one updates the architectural model
////////////////////////////////////////////////////////////////////////////

task automatic rtype(func_t fn, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
    word_t a;
    word_t b;
    word_t r;
    a = model_regs[rs1];
    b = model_regs[rs2];
    case (fn)
        FN_ADD:  r = a + b;
        FN_SUB:  r = a - b;
        FN_AND:  r = a & b;
        FN_OR:   r = a | b;
        FN_XOR:  r = a ^ b;
        default: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endcase
    prog.push_back(encode_r(fn, rd, rs1, rs2));
    model_regs[rd] = r;
    // r0 stays zero whatever was written
    model_regs[0] = '0;
endtask

task automatic immed(opcode_t op, reg_idx_t rd, reg_idx_t rs1, logic [15:0] imm);
    word_t a;
    a = model_regs[rs1];
    prog.push_back(encode_i(op, rs1, rd, imm));
    case (op)
        OP_ANDI: model_regs[rd] = a & {16'b0, imm};
        OP_ORI:  model_regs[rd] = a | {16'b0, imm};
        default: model_regs[rd] = a + sign_extend(imm);
    endcase
    model_regs[0] = '0;
endtask

// base r0, so the address is the immediate
task automatic load_word(reg_idx_t rd, logic [15:0] addr);
    prog.push_back(encode_i(OP_LW, 5'd0, rd, addr));
    model_regs[rd] = dmem[addr[11:2]];
    model_regs[0]  = '0;
endtask

// next free result slot, expected value from the model
task automatic store_word(reg_idx_t rs2);
    prog.push_back(encode_i(OP_SW, 5'd0, rs2, store_ptr[15:0]));
    exp_addr.push_back(store_ptr);
    exp_data.push_back(model_regs[rs2]);
    store_ptr = store_ptr + 32'd4;
endtask

// branch or jump over three stores, offset from the word after the leap
task automatic leap_over(opcode_t op, reg_idx_t rs1, reg_idx_t shadow_reg);
    logic taken;
    case (op)
        OP_BEQZ: taken = (model_regs[rs1] == '0);
        OP_BNEZ: taken = (model_regs[rs1] != '0);
        default: taken = 1'b1;
    endcase
    if (op == OP_J) begin
        prog.push_back(encode_j(26'd12));
    end else begin
        prog.push_back(encode_i(op, rs1, 5'd0, 16'd12));
    end
    repeat (3) begin
        if (taken) begin
            prog.push_back(encode_i(OP_SW, 5'd0, shadow_reg, POISON_ADDR[15:0]));
        end else begin
            store_word(shadow_reg);
        end
    end
endtask

task automatic build_programs();
    // alu chain, consumers one and two behind the producer
    load_word(5'd1, 16'h0200);
    load_word(5'd2, 16'h0204);
    rtype(FN_ADD, 5'd5, 5'd1, 5'd2);
    rtype(FN_SUB, 5'd6, 5'd5, 5'd1);
    rtype(FN_AND, 5'd7, 5'd5, 5'd6);
    rtype(FN_OR, 5'd8, 5'd7, 5'd2);
    rtype(FN_XOR, 5'd9, 5'd8, 5'd7);
    rtype(FN_SLT, 5'd12, 5'd9, 5'd8);
    rtype(FN_SLT, 5'd13, 5'd1, 5'd2);
    immed(OP_ADDI, 5'd14, 5'd13, rand16());
    immed(OP_ANDI, 5'd15, 5'd14, rand16());
    immed(OP_ORI, 5'd16, 5'd15, rand16());
    store_word(5'd16);
    for (int r = 5; r <= 15; r++) begin
        if (r != 10 && r != 11) begin
            store_word(reg_idx_t'(r));
        end
    end
    // load-use, stall then write-back forwarding
    load_word(5'd17, 16'h0208);
    immed(OP_ADDI, 5'd18, 5'd17, rand16());
    store_word(5'd18);
    // store data two behind its producer, then a load straight into a store
    rtype(FN_ADD, 5'd19, 5'd1, 5'd2);
    immed(OP_ADDI, 5'd20, 5'd0, rand16());
    store_word(5'd19);
    store_word(5'd20);
    load_word(5'd21, 16'h020c);
    store_word(5'd21);
    // taken beqz, not-taken bnez, j
    rtype(FN_XOR, 5'd10, 5'd1, 5'd1);
    leap_over(OP_BEQZ, 5'd10, 5'd1);
    immed(OP_ADDI, 5'd11, 5'd0, rand16());
    store_word(5'd11);
    leap_over(OP_BNEZ, 5'd10, 5'd11);
    leap_over(OP_J, 5'd0, 5'd11);
    rtype(FN_ADD, 5'd0, 5'd1, 5'd2);
    store_word(5'd0);
    // park on a jump to itself
    prog.push_back(encode_j(26'h3ff_fffc));
endtask

`endif

// File: tb/dlx_tb.sv
`timescale 1ns/1ps

module dlx_tb;
    import dlx_pkg::*;

    localparam word_t RESET_PC = word_t'(16'h0100);

    logic  clk;
    logic  arst_n;
    word_t imem_addr;
    word_t imem_instr;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_we;
    word_t dmem_rdata;

    word_t rom [1024];
    word_t dmem [1024];
    word_t prog [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t model_regs [32];
    word_t store_ptr = 32'h0000_0400;
    word_t lcg_state = 32'd79;
    word_t head_addr;
    word_t head_data;
    logic  built = 1'b0;
    int    errors = 0;
    int    stores_seen = 0;

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // upper half of the state because the low lcg bits repeat quickly
    function automatic logic [15:0] rand16();
        word_t w;
        w = lcg_next();
        return w[31:16];
    endfunction

    `include "dlx_programs.svh"

    dlx_core #(.RESET_PC(RESET_PC)) UUT (
        .clk(clk), .arst_n(arst_n), .imem_addr(imem_addr), .imem_instr(imem_instr),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_rdata(dmem_rdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // memory models answering within the cycle
    ////////////////////////////////////////////////////////////////////////////

    assign imem_instr = rom[imem_addr[11:2]];
    assign dmem_rdata = dmem[dmem_addr[11:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[11:2]] <= dmem_wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic idle_fetch_check(string phase);
        assert (!dmem_we && imem_addr == RESET_PC) else begin
            errors++;
            $display("error %0t: %s fetch %h we %b, expected fetch %h with no store",
                     $time, phase, imem_addr, dmem_we, RESET_PC);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // store checker sampled mid-cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (arst_n && dmem_we) begin
            stores_seen++;
            assert (dmem_addr != POISON_ADDR) else begin
                errors++;
                $display("error %0t: flushed instruction stored %h to %h",
                         $time, dmem_wdata, dmem_addr);
            end
            assert (exp_addr.size() != 0) else begin
                errors++;
                $display("error %0t: unexpected store of %h to %h", $time, dmem_wdata, dmem_addr);
            end
            if (exp_addr.size() != 0) begin
                head_addr = exp_addr.pop_front();
                head_data = exp_data.pop_front();
                assert (dmem_addr == head_addr && dmem_wdata == head_data) else begin
                    errors++;
                    $display("error %0t: store %h to %h, expected %h to %h",
                             $time, dmem_wdata, dmem_addr, head_data, head_addr);
                end
            end
        end
    end

    // main sequence
    initial begin
        arst_n = 1'b0;
        // fill tied to the word address
        // unused rom words carry an illegal opcode and decode as bubbles
        for (int i = 0; i < 1024; i++) begin
            rom[i]  = {6'h3f, 16'h0000, i[9:0]};
            dmem[i] = {20'hbad00, i[9:0], 2'b00};
        end
        // random load operands from 0x200 on
        for (int k = 0; k < 4; k++) begin
            dmem[128 + k] = lcg_next();
        end
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        build_programs();
        foreach (prog[k]) begin
            rom[RESET_PC[11:2] + k] = prog[k];
        end
        built = 1'b1;

        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            idle_fetch_check("reset");
            @(posedge clk);
        end
        #10 arst_n = 1'b1;
        @(negedge clk);
        idle_fetch_check("first cycle");

        while (exp_addr.size() != 0) begin
            @(posedge clk);
        end
        // a few more cycles to catch stray stores
        repeat (10) @(posedge clk);
        $display("stores checked %0d, errors %0d", stores_seen, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog allows four cycles per instruction for stalls and leaps
    initial begin
        int limit;
        wait (built);
        limit = prog.size() * 4 + 50;
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles, %0d stores never appeared", limit, exp_addr.size());
        foreach (exp_addr[i]) begin
            $display("store of %h to %h never appeared", exp_data[i], exp_addr[i]);
        end
        $display("stores checked %0d, errors %0d", stores_seen, errors + exp_addr.size());
        $display("Regression failed");
        $finish;
    end

endmodule

// File: dlx_pipe.f
+incdir+tb
hw/dlx_pkg.sv
hw/stage_reg.sv
hw/fetch_unit.sv
hw/register_file.sv
hw/decode_unit.sv
hw/execute_unit.sv
hw/hazard_unit.sv
hw/dlx_core.sv
tb/dlx_tb.sv
